//--- Bender.yml
package:
  name: p4_app

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/axis_pkg.sv
      - rtl/p4_app_pkg.sv
      - rtl/p4_app_regs.sv
      - rtl/meta_ingress.sv
      - rtl/match_action.sv
      - rtl/p4_app.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - test/tb_clock.sv
      - test/p4_app_props.sv
      - test/p4_app_tb.sv

//--- p4_app.f
+incdir+rtl
rtl/axis_pkg.sv
rtl/p4_app_pkg.sv
rtl/p4_app_regs.sv
rtl/meta_ingress.sv
rtl/match_action.sv
rtl/p4_app.sv
test/tb_clock.sv
test/p4_app_props.sv
test/p4_app_tb.sv

//--- rtl/axis_pkg.sv
`default_nettype none

`include "p4_app_config.svh"

package axis_pkg;

   // Field types of one stream beat
   typedef logic [`P4_DATA_W-1:0]   axis_tdata_t;
   typedef logic [`P4_DATA_W/8-1:0] axis_tkeep_t;
   typedef logic [`P4_TID_W-1:0]    axis_tid_t;
   typedef logic [`P4_TDEST_W-1:0]  axis_tdest_t;

   // Sideband carried in tuser on both switch ports
   typedef struct packed {
      logic [15:0] pid;
      logic        rss_enable;
      logic [11:0] rss_entropy;
   } axis_tuser_t;

   // Everything that moves with tvalid, tready excluded
   typedef struct packed {
      axis_tdata_t tdata;
      axis_tkeep_t tkeep;
      logic        tlast;
      axis_tid_t   tid;
      axis_tdest_t tdest;
      axis_tuser_t tuser;
   } axis_beat_t;

endpackage

`default_nettype wire

//--- rtl/match_action.sv
`timescale 1ns/1ns
`default_nettype none

`include "p4_app_config.svh"

module match_action
   import axis_pkg::*;
   import p4_app_pkg::*;
(
   input  logic        core_clk,
   input  logic        arst_n,

   input  logic        s_valid,
   input  p4_stage_t   s_stage,
   output logic        s_ready,

   input  p4_table_t   table_q,

   output logic        m_valid,
   output axis_beat_t  m_beat,
   input  logic        m_ready,

   output logic [31:0] drop_count
);

   localparam int IDX_W = $clog2(`P4_PORTS);

   p4_pkt_state_e    state;
   p4_entry_t        entry_q;
   p4_entry_t        cur_entry;
   logic [IDX_W-1:0] lookup_idx;
   logic             accept;
   logic             fwd;
   axis_beat_t       out_beat;

   assign s_ready = !m_valid || m_ready;
   assign accept  = s_valid && s_ready;

   // ---------------------------------------------------------
   // Table lookup
   // ---------------------------------------------------------

   assign lookup_idx = s_stage.meta.ingress_port[IDX_W-1:0];

   // Fresh lookup on the first beat, held decision afterwards
   assign cur_entry = (state == st_sop) ? table_q[lookup_idx] : entry_q;
   assign fwd       = (cur_entry.action == act_forward);

   always_ff @(posedge core_clk or negedge arst_n) begin
      if (!arst_n) begin
         state   <= st_sop;
         entry_q <= '0;
      end else if (accept) begin
         state <= s_stage.beat.tlast ? st_sop : st_body;
         if (state == st_sop) begin
            entry_q <= table_q[lookup_idx];
         end
      end
   end

   // Rewrite tdest and tuser, data fields pass unchanged
   always_comb begin
      out_beat                   = s_stage.beat;
      out_beat.tdest             = cur_entry.egress_port;
      out_beat.tuser.pid         = s_stage.meta.pid;
      out_beat.tuser.rss_enable  = cur_entry.rss_enable;
      out_beat.tuser.rss_entropy = s_stage.meta.rss_entropy;
   end

   // ---------------------------------------------------------
   // Output register
   // ---------------------------------------------------------

   // Dropped beats are taken in but never raise m_valid
   always_ff @(posedge core_clk or negedge arst_n) begin
      if (!arst_n) begin
         m_valid <= 1'b0;
      end else if (accept) begin
         m_valid <= fwd;
      end else if (m_ready) begin
         m_valid <= 1'b0;
      end
   end

   always_ff @(posedge core_clk) begin
      if (accept && fwd) begin
         m_beat <= out_beat;
      end
   end

   // ---------------------------------------------------------
   // Drop counter
   // ---------------------------------------------------------

   // One count per packet, taken on its last beat
   always_ff @(posedge core_clk or negedge arst_n) begin
      if (!arst_n) begin
         drop_count <= '0;
      end else if (accept && !fwd && s_stage.beat.tlast) begin
         drop_count <= drop_count + 32'd1;
      end
   end

endmodule

`default_nettype wire

//--- rtl/meta_ingress.sv
`timescale 1ns/1ns
`default_nettype none

`include "p4_app_config.svh"

module meta_ingress
   import axis_pkg::*;
   import p4_app_pkg::*;
(
   input  logic                core_clk,
   input  logic                arst_n,

   input  logic [`P4_TS_W-1:0] timestamp,

   input  logic                s_valid,
   input  axis_beat_t          s_beat,
   output logic                s_ready,

   output logic                m_valid,
   output p4_stage_t           m_stage,
   input  logic                m_ready
);

   p4_pkt_state_e state;
   p4_meta_t      sop_meta;
   logic          accept;

   // Load when empty or when the held beat leaves this cycle
   assign s_ready = !m_valid || m_ready;
   assign accept  = s_valid && s_ready;

   // Metadata as seen on the start-of-packet beat
   always_comb begin
      sop_meta.timestamp_ns = timestamp;
      sop_meta.pid          = s_beat.tuser.pid;
      sop_meta.rss_entropy  = s_beat.tuser.rss_entropy;
      sop_meta.ingress_port = {{(`P4_TDEST_W-`P4_TID_W){1'b0}}, s_beat.tid};
   end

   // ---------------------------------------------------------
   // Packet boundary tracking
   // ---------------------------------------------------------

   always_ff @(posedge core_clk or negedge arst_n) begin
      if (!arst_n) begin
         state <= st_sop;
      end else if (accept) begin
         state <= s_beat.tlast ? st_sop : st_body;
      end
   end

   // ---------------------------------------------------------
   // Output register
   // ---------------------------------------------------------

   always_ff @(posedge core_clk or negedge arst_n) begin
      if (!arst_n) begin
         m_valid <= 1'b0;
      end else if (accept) begin
         m_valid <= 1'b1;
      end else if (m_ready) begin
         m_valid <= 1'b0;
      end
   end

   // Meta field is only reloaded at packet start, so it
   // doubles as the per-packet hold for the body beats
   always_ff @(posedge core_clk) begin
      if (accept) begin
         m_stage.beat <= s_beat;
         if (state == st_sop) begin
            m_stage.meta <= sop_meta;
         end
      end
   end

endmodule

`default_nettype wire

//--- rtl/p4_app.sv
`timescale 1ns/1ns
`default_nettype none

`include "p4_app_config.svh"

module p4_app
   import axis_pkg::*;
   import p4_app_pkg::*;
(
   input  logic                core_clk,
   input  logic                arst_n,
   input  logic [`P4_TS_W-1:0] timestamp,

   // Channel 0, processed
   input  logic                s0_valid,
   input  axis_beat_t          s0_beat,
   output logic                s0_ready,
   output logic                m0_valid,
   output axis_beat_t          m0_beat,
   input  logic                m0_ready,

   // Channel 1, bypass
   input  logic                s1_valid,
   input  axis_beat_t          s1_beat,
   output logic                s1_ready,
   output logic                m1_valid,
   output axis_beat_t          m1_beat,
   input  logic                m1_ready,

   // Register port
   input  logic                reg_wr,
   input  logic                reg_rd,
   input  p4_reg_addr_e        reg_addr,
   input  p4_entry_t           reg_wdata,
   output logic [31:0]         reg_rdata,
   output logic                reg_rvalid
);

   logic        stage_valid;
   logic        stage_ready;
   p4_stage_t   stage;
   p4_table_t   table_q;
   logic [31:0] drop_count;

   // ---------------------------------------------------------
   // Channel 0 pipeline
   // ---------------------------------------------------------

   meta_ingress meta_ingress_i (
      .core_clk  (core_clk),
      .arst_n    (arst_n),
      .timestamp (timestamp),
      .s_valid   (s0_valid),
      .s_beat    (s0_beat),
      .s_ready   (s0_ready),
      .m_valid   (stage_valid),
      .m_stage   (stage),
      .m_ready   (stage_ready)
   );

   match_action match_action_i (
      .core_clk   (core_clk),
      .arst_n     (arst_n),
      .s_valid    (stage_valid),
      .s_stage    (stage),
      .s_ready    (stage_ready),
      .table_q    (table_q),
      .m_valid    (m0_valid),
      .m_beat     (m0_beat),
      .m_ready    (m0_ready),
      .drop_count (drop_count)
   );

   p4_app_regs p4_app_regs_i (
      .core_clk   (core_clk),
      .arst_n     (arst_n),
      .reg_wr     (reg_wr),
      .reg_rd     (reg_rd),
      .reg_addr   (reg_addr),
      .reg_wdata  (reg_wdata),
      .reg_rdata  (reg_rdata),
      .reg_rvalid (reg_rvalid),
      .table_q    (table_q),
      .drop_count (drop_count)
   );

   // Channel 1 is wired straight through, no register
   assign m1_valid = s1_valid;
   assign m1_beat  = s1_beat;
   assign s1_ready = m1_ready;

endmodule

`default_nettype wire

//--- rtl/p4_app_config.svh
`ifndef P4_APP_CONFIG_SVH
`define P4_APP_CONFIG_SVH

// ---------------------------------------------------------
// Stream geometry
// ---------------------------------------------------------

// Data bus width, tkeep follows as one bit per byte
`define P4_DATA_W   64

// Stream id carries the ingress port number
`define P4_TID_W    2

// Egress port field width on the to-switch side
`define P4_TDEST_W  3

// ---------------------------------------------------------
// Match-action sizing
// ---------------------------------------------------------

// One action table entry per ingress port
`define P4_PORTS    4

// Free-running nanosecond timestamp from the card
`define P4_TS_W     64

`endif

//--- rtl/p4_app_pkg.sv
`default_nettype none

`include "p4_app_config.svh"

package p4_app_pkg;

   // What to do with a packet from a given ingress port
   typedef enum logic {
      act_forward = 1'b0,
      act_drop    = 1'b1
   } p4_action_e;

   // One action table entry, all zero means forward to port 0
   typedef struct packed {
      p4_action_e              action;
      logic [`P4_TDEST_W-1:0]  egress_port;
      logic                    rss_enable;
   } p4_entry_t;

   typedef p4_entry_t [`P4_PORTS-1:0] p4_table_t;

   // Per-packet metadata, captured on the start-of-packet beat
   typedef struct packed {
      logic [`P4_TS_W-1:0]     timestamp_ns;
      logic [15:0]             pid;
      logic [`P4_TDEST_W-1:0]  ingress_port;
      logic [11:0]             rss_entropy;
   } p4_meta_t;

   // Beat plus its packet metadata between the two stages
   typedef struct packed {
      axis_pkg::axis_beat_t beat;
      p4_meta_t             meta;
   } p4_stage_t;

   // Register map
   typedef enum logic [2:0] {
      reg_entry0     = 3'd0,
      reg_entry1     = 3'd1,
      reg_entry2     = 3'd2,
      reg_entry3     = 3'd3,
      reg_drop_count = 3'd4
   } p4_reg_addr_e;

   typedef enum logic {
      st_sop,
      st_body
   } p4_pkt_state_e;

endpackage

`default_nettype wire

//--- rtl/p4_app_regs.sv
`timescale 1ns/1ns
`default_nettype none

`include "p4_app_config.svh"

module p4_app_regs
   import p4_app_pkg::*;
(
   input  logic         core_clk,
   input  logic         arst_n,

   input  logic         reg_wr,
   input  logic         reg_rd,
   input  p4_reg_addr_e reg_addr,
   input  p4_entry_t    reg_wdata,
   output logic [31:0]  reg_rdata,
   output logic         reg_rvalid,

   output p4_table_t    table_q,
   input  logic [31:0]  drop_count
);

   localparam int IDX_W = $clog2(`P4_PORTS);
   localparam int PAD_W = 32 - $bits(p4_entry_t);

   logic             is_entry;
   logic [IDX_W-1:0] entry_idx;
   logic [31:0]      rd_mux;

   // Addresses below the port count select a table entry
   assign is_entry  = (int'(reg_addr) < `P4_PORTS);
   assign entry_idx = reg_addr[IDX_W-1:0];

   // ---------------------------------------------------------
   // Action table
   // ---------------------------------------------------------

   always_ff @(posedge core_clk or negedge arst_n) begin
      if (!arst_n) begin
         table_q <= '0;
      end else if (reg_wr && is_entry) begin
         table_q[entry_idx] <= reg_wdata;
      end
   end

   // ---------------------------------------------------------
   // Read path
   // ---------------------------------------------------------

   always_comb begin
      rd_mux = '0;
      if (reg_addr == reg_drop_count) begin
         rd_mux = drop_count;
      end else if (is_entry) begin
         // Entry is zero-extended into the data word
         rd_mux = {{PAD_W{1'b0}}, table_q[entry_idx]};
      end
   end

   always_ff @(posedge core_clk or negedge arst_n) begin
      if (!arst_n) begin
         reg_rvalid <= 1'b0;
      end else begin
         reg_rvalid <= reg_rd;
      end
   end

   // Data only changes on a read, holds otherwise
   always_ff @(posedge core_clk) begin
      if (reg_rd) begin
         reg_rdata <= rd_mux;
      end
   end

endmodule

`default_nettype wire

//--- test/p4_app_props.sv
`timescale 1ns/1ns
`default_nettype none

module p4_app_props
   import axis_pkg::*;
(
   input logic       core_clk,
   input logic       arst_n,
   input logic       m0_valid,
   input logic       m0_ready,
   input axis_beat_t m0_beat,
   input logic       reg_rd,
   input logic       reg_rvalid
);

   int fail_count = 0;

   // Registered valids are held low while reset is applied
   no_valid_in_reset: assert property (
      @(posedge core_clk) !arst_n |-> (!m0_valid && !reg_rvalid)
   ) else begin
      $error("m0_valid or reg_rvalid high during reset");
      fail_count++;
   end

   // A stalled beat must not move or change
   m0_hold_when_stalled: assert property (
      @(posedge core_clk) disable iff (!arst_n)
      (m0_valid && !m0_ready) |=> (m0_valid && $stable(m0_beat))
   ) else begin
      $error("m0 beat dropped or changed while stalled");
      fail_count++;
   end

   // Read valid is a one cycle echo of the read strobe
   rvalid_after_rd: assert property (
      @(posedge core_clk) disable iff (!arst_n)
      reg_rd |=> reg_rvalid
   ) else begin
      $error("reg_rvalid missing one cycle after reg_rd");
      fail_count++;
   end

   no_rvalid_without_rd: assert property (
      @(posedge core_clk) disable iff (!arst_n)
      !reg_rd |=> !reg_rvalid
   ) else begin
      $error("reg_rvalid raised without a preceding reg_rd");
      fail_count++;
   end

endmodule

`default_nettype wire

//--- test/p4_app_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "p4_app_config.svh"

module p4_app_tb
   import axis_pkg::*;
   import p4_app_pkg::*;
();

   localparam int N_PHASES = 6;
   localparam int N_PKTS   = 24;
   localparam int PAD_W    = 32 - $bits(p4_entry_t);

   logic                core_clk;
   logic                arst_n;
   logic [`P4_TS_W-1:0] timestamp;
   logic                s0_valid, s0_ready, m0_valid, m0_ready;
   logic                s1_valid, s1_ready, m1_valid, m1_ready;
   axis_beat_t          s0_beat, m0_beat, s1_beat, m1_beat;
   logic                reg_wr, reg_rd, reg_rvalid;
   p4_reg_addr_e        reg_addr;
   p4_entry_t           reg_wdata;
   logic [31:0]         reg_rdata;

   // Model state
   p4_entry_t   model_tbl [`P4_PORTS];
   axis_beat_t  exp_q [$];
   int          drops_exp = 0;
   int          beats_gen = 0;
   int          cycles = 0;
   int          err_value = 0;
   int          err_other = 0;
   logic [31:0] rng_main = 32'he817;
   logic [31:0] rng_bg = ~32'he817;

   tb_clock #(.PERIOD_NS(8)) clock_i (.core_clk(core_clk));

   p4_app dut_i (.*);

   bind p4_app p4_app_props props_i (.*);

   // ---------------------------------------------------------
   // Random numbers
   // ---------------------------------------------------------

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function automatic logic [31:0] next_rand();
      rng_main = xorshift32(rng_main);
      return rng_main;
   endfunction

   // Separate stream for the free-running drivers
   function automatic logic [31:0] next_bg_rand();
      rng_bg = xorshift32(rng_bg);
      return rng_bg;
   endfunction

   // ---------------------------------------------------------
   // Checks and reporting
   // ---------------------------------------------------------

   task automatic check_field(input string name, input logic [127:0] got,
                              input logic [127:0] exp);
      assert (got === exp) else begin
         $display("[ERROR] %0t %s got %0h expected %0h", $time, name, got, exp);
         err_value++;
      end
   endtask

   task automatic report_and_finish();
      int n_prop;
      n_prop = dut_i.props_i.fail_count;
      $display("Errors: %0d value mismatches, %0d other failures, %0d assertion failures",
               err_value, err_other, n_prop);
      if (err_value + err_other + n_prop == 0) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   endtask

   // ---------------------------------------------------------
   // Register port tasks start and end on a falling edge
   // ---------------------------------------------------------

   task automatic write_entry(input int idx, input p4_entry_t ent);
      reg_wr    = 1'b1;
      reg_addr  = p4_reg_addr_e'(idx);
      reg_wdata = ent;
      @(negedge core_clk);
      reg_wr = 1'b0;
      model_tbl[idx] = ent;
   endtask

   task automatic read_check(input p4_reg_addr_e addr, input logic [31:0] expected);
      reg_rd   = 1'b1;
      reg_addr = addr;
      @(negedge core_clk);
      reg_rd = 1'b0;
      assert (reg_rvalid) else begin
         $display("Read of address %0d gave no reg_rvalid pulse", addr);
         err_other++;
      end
      check_field("reg_rdata", reg_rdata, expected);
   endtask

   task automatic program_table();
      logic [31:0] r;
      p4_entry_t   ent;
      for (int a = 0; a < `P4_PORTS; a++) begin
         r = next_rand();
         ent.action      = (r[1:0] == 2'b00) ? act_drop : act_forward;
         ent.egress_port = r[4:2];
         ent.rss_enable  = r[5];
         write_entry(a, ent);
      end
      // Overwrite one entry so reads see the later value
      r = next_rand();
      ent.action      = (r[9:8] == 2'b00) ? act_drop : act_forward;
      ent.egress_port = r[12:10];
      ent.rss_enable  = r[13];
      write_entry(int'(r % `P4_PORTS), ent);
   endtask

   // ---------------------------------------------------------
   // Channel 0 stimulus and prediction
   // ---------------------------------------------------------

   task automatic send_packet();
      int                   len;
      int                   gap;
      logic [31:0]          r;
      logic [`P4_TID_W-1:0] tid;
      p4_entry_t            ent;
      axis_beat_t           b;
      axis_beat_t           e;
      logic [15:0]          pid0;
      logic [11:0]          entropy0;
      len = 1 + int'(next_rand() % 8);
      r   = next_rand();
      tid = r[`P4_TID_W-1:0];
      ent = model_tbl[tid];
      beats_gen += len;
      if (ent.action == act_drop) begin
         drops_exp++;
      end
      for (int i = 0; i < len; i++) begin
         b.tdata = {next_rand(), next_rand()};
         r = next_rand();
         b.tkeep = r[7:0];
         b.tdest = r[10:8];
         b.tlast = (i == len - 1);
         b.tid   = tid;
         r = next_rand();
         b.tuser = r[$bits(axis_tuser_t)-1:0];
         if (i == 0) begin
            pid0     = b.tuser.pid;
            entropy0 = b.tuser.rss_entropy;
         end
         if (ent.action == act_forward) begin
            e = b;
            e.tdest             = ent.egress_port;
            e.tuser.pid         = pid0;
            e.tuser.rss_enable  = ent.rss_enable;
            e.tuser.rss_entropy = entropy0;
            exp_q.push_back(e);
         end
         r   = next_rand();
         gap = (r[1:0] == 2'b00) ? 1 + int'(r[3:2]) : 0;
         repeat (gap) @(negedge core_clk);
         s0_valid = 1'b1;
         s0_beat  = b;
         @(posedge core_clk);
         while (!s0_ready) @(posedge core_clk);
         @(negedge core_clk);
         s0_valid = 1'b0;
      end
   endtask

   // Both stages are empty once all forwarded beats are out
   task automatic wait_drain();
      while (exp_q.size() != 0) @(negedge core_clk);
      repeat (4) @(negedge core_clk);
   endtask

   // ---------------------------------------------------------
   // Free-running drivers, monitors and timeout
   // ---------------------------------------------------------

   always @(negedge core_clk) begin : bg_drive
      logic [31:0]  r;
      logic [127:0] wide;
      r         = next_bg_rand();
      m0_ready  = (r % 10) < 7;
      s1_valid  = r[31];
      m1_ready  = r[30];
      wide      = {next_bg_rand(), next_bg_rand(), next_bg_rand(), next_bg_rand()};
      s1_beat   = wide[$bits(axis_beat_t)-1:0];
      timestamp = timestamp + 64'd8;
   end

   always @(posedge core_clk) begin : monitor
      axis_beat_t e;
      if (arst_n && m0_valid && m0_ready) begin
         assert (exp_q.size() != 0) else begin
            $display("Beat on m0 at %0t with no beat expected", $time);
            err_other++;
         end
         if (exp_q.size() != 0) begin
            e = exp_q.pop_front();
            check_field("m0_beat.tdata", m0_beat.tdata, e.tdata);
            check_field("m0_beat.tkeep", m0_beat.tkeep, e.tkeep);
            check_field("m0_beat.tlast", m0_beat.tlast, e.tlast);
            check_field("m0_beat.tid", m0_beat.tid, e.tid);
            check_field("m0_beat.tdest", m0_beat.tdest, e.tdest);
            check_field("m0_beat.tuser.pid", m0_beat.tuser.pid, e.tuser.pid);
            check_field("m0_beat.tuser.rss_enable", m0_beat.tuser.rss_enable,
                        e.tuser.rss_enable);
            check_field("m0_beat.tuser.rss_entropy", m0_beat.tuser.rss_entropy,
                        e.tuser.rss_entropy);
         end
      end
      // Bypass outputs follow their inputs in the same cycle
      check_field("m1_valid", m1_valid, s1_valid);
      check_field("m1_beat", m1_beat, s1_beat);
      check_field("s1_ready", s1_ready, m1_ready);
   end

   always @(posedge core_clk) begin : watchdog
      cycles++;
      if (cycles > 2000 + 40 * beats_gen) begin
         $display("Timeout after %0d cycles, %0d beats still expected", cycles, exp_q.size());
         err_other++;
         report_and_finish();
      end
   end

   // ---------------------------------------------------------
   // Test sequence
   // ---------------------------------------------------------

   initial begin
      arst_n    = 1'b1;
      timestamp = '0;
      s0_valid  = 1'b0;
      s0_beat   = '0;
      m0_ready  = 1'b0;
      s1_valid  = 1'b0;
      s1_beat   = '0;
      m1_ready  = 1'b0;
      reg_wr    = 1'b0;
      reg_rd    = 1'b0;
      reg_addr  = reg_entry0;
      reg_wdata = '0;
      for (int a = 0; a < `P4_PORTS; a++) begin
         model_tbl[a] = '0;
      end
      // Reset falls after time zero so every flop catches the edge
      #1;
      arst_n = 1'b0;
      repeat (8) @(posedge core_clk);
      @(negedge core_clk);
      arst_n = 1'b1;
      @(negedge core_clk);
      // Phase 0 runs on the reset table
      for (int ph = 0; ph < N_PHASES; ph++) begin
         if (ph > 0) begin
            program_table();
         end
         for (int a = 0; a < `P4_PORTS; a++) begin
            read_check(p4_reg_addr_e'(a), {{PAD_W{1'b0}}, model_tbl[a]});
         end
         for (int p = 0; p < N_PKTS; p++) begin
            send_packet();
         end
         wait_drain();
         read_check(reg_drop_count, drops_exp);
      end
      report_and_finish();
   end

endmodule

`default_nettype wire

//--- test/tb_clock.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clock #(
   parameter int PERIOD_NS = 8
) (
   output logic core_clk
);

   initial begin
      core_clk = 1'b0;
   end

   always #(PERIOD_NS/2) core_clk = ~core_clk;

endmodule

`default_nettype wire
